// File: flist.f
rtl/pcxt_ctrl_pkg.sv
rtl/status_decode.sv
rtl/reset_sequencer.sv
rtl/rom_byte_loader.sv
rtl/sample_rate_gen.sv
rtl/pcxt_ctrl_top.sv
tb/pcxt_ctrl_sva.sv
tb/tb_pcxt_ctrl.sv

// File: rtl/pcxt_ctrl_pkg.sv
package pcxt_ctrl_pkg;

	////////////////////////////////////////
	// Bus and word widths
	////////////////////////////////////////

	localparam int STATUS_W    = 64;
	localparam int ROM_ADDR_W  = 25;
	localparam int ROM_INDEX_W = 8;

	// Reset timing, counter widths follow the constants
	localparam logic [15:0] RESET_HOLD_CYCLES = 16'd65535;
	localparam logic [5:0]  CPU_RESET_DELAY   = 6'd42;

	// Audio sample enable from the system clock
	localparam logic [31:0] SYS_CLOCK_HZ   = 32'd50_000_000;
	localparam logic [31:0] SAMPLE_RATE_HZ = 32'd44_100;

	// Mainboard DIP switches, MDA or CGA 80 columns
	localparam logic [7:0] DIP_SW_MDA = 8'b00111101;
	localparam logic [7:0] DIP_SW_CGA = 8'b00101101;

	// Plain 4:3 when no aspect override is selected
	localparam logic [12:0] ASPECT_DEFAULT_X = 13'd4;
	localparam logic [12:0] ASPECT_DEFAULT_Y = 13'd3;

	////////////////////////////////////////
	// Menu status bit positions (LSB of each field)
	////////////////////////////////////////

	localparam int ST_SCALE      = 1;   // 2 bits
	localparam int ST_TANDY      = 3;
	localparam int ST_MDA        = 4;
	localparam int ST_ASPECT     = 8;   // 2 bits
	localparam int ST_ADLIB_HIDE = 10;
	localparam int ST_EMS_OFF    = 11;
	localparam int ST_EMS_FRAME  = 12;  // 2 bits
	localparam int ST_SCREEN     = 14;  // 3 bits
	localparam int ST_SPEED      = 17;  // 2 bits
	localparam int ST_WP         = 19;  // 2 bits

	// ROM loader states
	localparam logic [1:0] LD_IDLE = 2'd0;
	localparam logic [1:0] LD_HIGH = 2'd1;
	localparam logic [1:0] LD_HOLD = 2'd2;

	// Host download word, whole or split in bytes
	typedef union packed {
		logic [15:0] word;
		struct packed {
			logic [7:0] hi;
			logic [7:0] lo;
		} bytes;
	} rom_word_t;

endpackage

// File: rtl/pcxt_ctrl_top.sv
`timescale 1ns/1ps

module pcxt_ctrl_top (
	input  logic                                  CLK_50M,
	input  logic                                  reset_wire,
	// Menu and CPU side
	input  logic [pcxt_ctrl_pkg::STATUS_W-1:0]    status,
	input  logic                                  biu_done,
	input  logic                                  port_b_sel,
	// Host download
	input  logic                                  ioctl_wr,
	input  logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0]  ioctl_addr,
	input  logic [15:0]                           ioctl_data,
	input  logic                                  ioctl_download,
	input  logic [pcxt_ctrl_pkg::ROM_INDEX_W-1:0] ioctl_index,
	// Machine configuration
	output logic                                  tandy_mode,
	output logic                                  mda_mode,
	output logic                                  adlib_hide,
	output logic                                  ems_enabled,
	output logic [1:0]                            ems_frame,
	output logic [1:0]                            cpu_speed,
	output logic [1:0]                            floppy_wp,
	output logic [2:0]                            screen_mode,
	output logic [1:0]                            vga_sl,
	output logic                                  scandoubler,
	output logic                                  hq2x,
	output logic                                  color_mode,
	output logic                                  turbo_mode,
	output logic [12:0]                           video_arx,
	output logic [12:0]                           video_ary,
	output logic [3:0]                            dip_nibble,
	// ROM byte writes
	output logic                                  ioctl_wait,
	output logic                                  rom_wr,
	output logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0]  rom_addr,
	output logic [7:0]                            rom_data,
	output logic                                  rom_download,
	output logic [pcxt_ctrl_pkg::ROM_INDEX_W-1:0] rom_index,
	// Resets and audio enable
	output logic                                  sys_reset,
	output logic                                  cpu_reset,
	output logic                                  sample_en
);

	// Menu word to configuration
	status_decode i_decode (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.status     (status),
		.biu_done   (biu_done),
		.port_b_sel (port_b_sel),
		.tandy_mode (tandy_mode),
		.mda_mode   (mda_mode),
		.adlib_hide (adlib_hide),
		.ems_enabled(ems_enabled),
		.ems_frame  (ems_frame),
		.cpu_speed  (cpu_speed),
		.floppy_wp  (floppy_wp),
		.screen_mode(screen_mode),
		.vga_sl     (vga_sl),
		.scandoubler(scandoubler),
		.hq2x       (hq2x),
		.color_mode (color_mode),
		.turbo_mode (turbo_mode),
		.video_arx  (video_arx),
		.video_ary  (video_ary),
		.dip_nibble (dip_nibble)
	);

	// Word to byte splitter
	rom_byte_loader i_loader (
		.CLK_50M       (CLK_50M),
		.reset_wire    (reset_wire),
		.ioctl_wr      (ioctl_wr),
		.ioctl_addr    (ioctl_addr),
		.ioctl_data    (ioctl_data),
		.ioctl_download(ioctl_download),
		.ioctl_index   (ioctl_index),
		.ioctl_wait    (ioctl_wait),
		.rom_wr        (rom_wr),
		.rom_addr      (rom_addr),
		.rom_data      (rom_data),
		.rom_download  (rom_download),
		.rom_index     (rom_index)
	);

	reset_sequencer i_reset (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.sys_reset (sys_reset),
		.cpu_reset (cpu_reset)
	);

	// 44.1 kHz enable
	sample_rate_gen i_sample (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.sample_en (sample_en)
	);

endmodule

// File: rtl/reset_sequencer.sv
`timescale 1ns/1ps

module reset_sequencer (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic sys_reset,
	output logic cpu_reset
);

	// Counters sized by their limits
	logic [15:0] hold_cnt;
	logic [5:0]  delay_cnt;
	logic        sys_reset_q;

	////////////////////////////////////////
	// System reset stretch
	////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset <= 1'b1;
			hold_cnt  <= 16'd0;
		end else if (sys_reset) begin
			// Release on the edge after the last count
			if (hold_cnt != pcxt_ctrl_pkg::RESET_HOLD_CYCLES) begin
				hold_cnt <= hold_cnt + 16'd1;
			end else begin
				sys_reset <= 1'b0;
			end
		end
	end

	////////////////////////////////////////
	// CPU reset delay
	////////////////////////////////////////

	// One flop behind the system reset
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset_q <= 1'b1;
		end else begin
			sys_reset_q <= sys_reset;
		end
	end

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_reset <= 1'b1;
			delay_cnt <= 6'd0;
		end else if (sys_reset || sys_reset_q) begin
			// Hold and restart while either stage is active
			cpu_reset <= 1'b1;
			delay_cnt <= 6'd0;
		end else if (cpu_reset) begin
			if (delay_cnt != pcxt_ctrl_pkg::CPU_RESET_DELAY) begin
				delay_cnt <= delay_cnt + 6'd1;
			end else begin
				// 44 clocks after sys_reset drops
				cpu_reset <= 1'b0;
			end
		end
	end

endmodule

// File: rtl/rom_byte_loader.sv
`timescale 1ns/1ps

module rom_byte_loader (
	input  logic                                  CLK_50M,
	input  logic                                  reset_wire,
	input  logic                                  ioctl_wr,
	input  logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0]  ioctl_addr,
	input  logic [15:0]                           ioctl_data,
	input  logic                                  ioctl_download,
	input  logic [pcxt_ctrl_pkg::ROM_INDEX_W-1:0] ioctl_index,
	output logic                                  ioctl_wait,
	output logic                                  rom_wr,
	output logic [pcxt_ctrl_pkg::ROM_ADDR_W-1:0]  rom_addr,
	output logic [7:0]                            rom_data,
	output logic                                  rom_download,
	output logic [pcxt_ctrl_pkg::ROM_INDEX_W-1:0] rom_index
);

	logic [1:0]               state;
	pcxt_ctrl_pkg::rom_word_t host_word;
	// Odd byte held for the second write
	logic [7:0]               hi_byte;

	assign host_word.word = ioctl_data;

	////////////////////////////////////////
	// FSM and handshake
	////////////////////////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			state      <= pcxt_ctrl_pkg::LD_IDLE;
			rom_wr     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			case (state)
				pcxt_ctrl_pkg::LD_IDLE: begin
					// New word, low byte goes out next
					rom_wr     <= ioctl_wr;
					ioctl_wait <= ioctl_wr;
					if (ioctl_wr) begin
						state <= pcxt_ctrl_pkg::LD_HIGH;
					end
				end
				pcxt_ctrl_pkg::LD_HIGH: begin
					state      <= pcxt_ctrl_pkg::LD_HOLD;
					rom_wr     <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				pcxt_ctrl_pkg::LD_HOLD: begin
					rom_wr     <= 1'b0;
					ioctl_wait <= 1'b0;
					// Wait for the host strobe to drop
					if (!ioctl_wr) begin
						state <= pcxt_ctrl_pkg::LD_IDLE;
					end
				end
				default: begin
					state      <= pcxt_ctrl_pkg::LD_IDLE;
					rom_wr     <= 1'b0;
					ioctl_wait <= 1'b0;
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Byte payload
	////////////////////////////////////////

	always_ff @(posedge CLK_50M) begin
		if ((state == pcxt_ctrl_pkg::LD_IDLE) && ioctl_wr) begin
			hi_byte      <= host_word.bytes.hi;
			rom_addr     <= ioctl_addr;
			rom_data     <= host_word.bytes.lo;
			rom_download <= ioctl_download;
			rom_index    <= ioctl_index;
		end else if (state == pcxt_ctrl_pkg::LD_HIGH) begin
			// Odd byte at the next address
			rom_addr <= rom_addr + {{(pcxt_ctrl_pkg::ROM_ADDR_W-1){1'b0}}, 1'b1};
			rom_data <= hi_byte;
		end else begin
			rom_addr     <= '0;
			rom_data     <= 8'd0;
			rom_download <= 1'b0;
			rom_index    <= '0;
		end
	end

endmodule

// File: rtl/sample_rate_gen.sv
`timescale 1ns/1ps

module sample_rate_gen (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic sample_en
);

	// Phase in units of one sample period
	logic [31:0] acc;
	logic [31:0] acc_next;

	assign acc_next = acc + pcxt_ctrl_pkg::SAMPLE_RATE_HZ;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc       <= 32'd0;
			sample_en <= 1'b0;
		end else if (acc_next >= pcxt_ctrl_pkg::SYS_CLOCK_HZ) begin
			// Wrap and emit one enable
			acc       <= acc_next - pcxt_ctrl_pkg::SYS_CLOCK_HZ;
			sample_en <= 1'b1;
		end else begin
			acc       <= acc_next;
			sample_en <= 1'b0;
		end
	end

endmodule

// File: rtl/status_decode.sv
`timescale 1ns/1ps

module status_decode (
	input  logic                               CLK_50M,
	input  logic                               reset_wire,
	input  logic [pcxt_ctrl_pkg::STATUS_W-1:0] status,
	input  logic                               biu_done,
	input  logic                               port_b_sel,
	output logic                               tandy_mode,
	output logic                               mda_mode,
	output logic                               adlib_hide,
	output logic                               ems_enabled,
	output logic [1:0]                         ems_frame,
	output logic [1:0]                         cpu_speed,
	output logic [1:0]                         floppy_wp,
	output logic [2:0]                         screen_mode,
	output logic [1:0]                         vga_sl,
	output logic                               scandoubler,
	output logic                               hq2x,
	output logic                               color_mode,
	output logic                               turbo_mode,
	output logic [12:0]                        video_arx,
	output logic [12:0]                        video_ary,
	output logic [3:0]                         dip_nibble
);

	// Multi-bit menu fields
	logic [1:0] scale;
	logic [1:0] aspect;
	logic [1:0] speed;
	logic [2:0] screen;
	logic [7:0] dip_sw;

	assign scale  = status[pcxt_ctrl_pkg::ST_SCALE +: 2];
	assign aspect = status[pcxt_ctrl_pkg::ST_ASPECT +: 2];
	assign speed  = status[pcxt_ctrl_pkg::ST_SPEED +: 2];
	assign screen = status[pcxt_ctrl_pkg::ST_SCREEN +: 3];

	// Switch byte follows the selected adapter
	assign dip_sw = status[pcxt_ctrl_pkg::ST_MDA] ? pcxt_ctrl_pkg::DIP_SW_MDA
		: pcxt_ctrl_pkg::DIP_SW_CGA;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			tandy_mode  <= 1'b0;
			mda_mode    <= 1'b0;
			adlib_hide  <= 1'b0;
			ems_enabled <= 1'b0;
			ems_frame   <= 2'd0;
			cpu_speed   <= 2'd0;
			floppy_wp   <= 2'd0;
			screen_mode <= 3'd0;
			vga_sl      <= 2'd0;
			scandoubler <= 1'b0;
			hq2x        <= 1'b0;
			color_mode  <= 1'b0;
			turbo_mode  <= 1'b0;
			video_arx   <= pcxt_ctrl_pkg::ASPECT_DEFAULT_X;
			video_ary   <= pcxt_ctrl_pkg::ASPECT_DEFAULT_Y;
			dip_nibble  <= 4'd0;
		end else begin
			tandy_mode  <= status[pcxt_ctrl_pkg::ST_TANDY];
			mda_mode    <= status[pcxt_ctrl_pkg::ST_MDA];
			adlib_hide  <= status[pcxt_ctrl_pkg::ST_ADLIB_HIDE];
			// Menu bit is a disable
			ems_enabled <= ~status[pcxt_ctrl_pkg::ST_EMS_OFF];
			ems_frame   <= status[pcxt_ctrl_pkg::ST_EMS_FRAME +: 2];
			cpu_speed   <= speed;
			floppy_wp   <= status[pcxt_ctrl_pkg::ST_WP +: 2];
			screen_mode <= screen;
			// Scanline strength, 25% or 50%
			vga_sl      <= {scale == 2'd3, scale == 2'd2};
			scandoubler <= (scale != 2'd0);
			hq2x        <= (scale == 2'd1);
			// Full color display only
			color_mode  <= (screen == 3'd0);
			if (aspect == 2'd0) begin
				video_arx <= pcxt_ctrl_pkg::ASPECT_DEFAULT_X;
				video_ary <= pcxt_ctrl_pkg::ASPECT_DEFAULT_Y;
			end else begin
				// Codes 1..3 select full screen or ARC presets
				video_arx <= {11'd0, aspect - 2'd1};
				video_ary <= 13'd0;
			end
			// Turbo changes only at a BIU boundary
			if (biu_done) begin
				turbo_mode <= (speed == 2'd1) || (speed == 2'd2);
			end
			// Port B bit 3 picks the switch nibble on port C
			dip_nibble <= port_b_sel ? dip_sw[7:4] : dip_sw[3:0];
		end
	end

endmodule

// File: run_sim.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_pcxt_ctrl \
	-f flist.f -o sim_pcxt

./obj_dir/sim_pcxt | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// File: tb/pcxt_ctrl_sva.sv
`timescale 1ns/1ps

module pcxt_ctrl_sva (
	input logic CLK_50M,
	input logic reset_wire,
	input logic rom_wr,
	input logic ioctl_wait,
	input logic sys_reset,
	input logic cpu_reset
);

	// Host is held for every byte write
	assert property (@(posedge CLK_50M) disable iff (reset_wire) rom_wr |-> ioctl_wait)
		else $error("byte write without host wait");

	// Two bytes per word at most
	assert property (@(posedge CLK_50M) disable iff (reset_wire)
		rom_wr ##1 rom_wr |=> !rom_wr)
		else $error("byte write strobe longer than two clocks");

	// CPU stays in reset under the system reset
	assert property (@(posedge CLK_50M) disable iff (reset_wire) sys_reset |-> cpu_reset)
		else $error("CPU reset released before system reset");

endmodule

bind pcxt_ctrl_top pcxt_ctrl_sva i_sva (.*);

// File: tb/pcxt_ctrl_tests.txt
# D status port_b_sel | tandy mda adlib ems frame speed wp screen vga_sl sd hq2x color arx ary dip
# T speed biu_done | turbo ; L addr index download
D 0000000000000000 0 0 0 0 1 0 0 0 0 0 0 0 1 4 3 d
D 000000000000001a 1 1 1 0 1 0 0 0 0 0 1 1 1 4 3 3
D ffffffff000d7e06 0 0 0 1 0 3 2 1 5 2 1 0 0 1 0 d
D 00000000001fc314 0 0 1 0 1 0 3 3 7 1 1 0 0 2 0 d
D 0000000000000100 1 0 0 0 1 0 0 0 0 0 0 0 1 0 0 2
T 1 0 0
T 1 1 1
T 3 0 1
T 3 1 0
T 2 1 1
T 0 0 1
T 0 1 0
L 0000000 00 1
L 0000100 03 1
L 00f0ffe 01 1
L 1ffffff 07 0

// File: tb/tb_pcxt_ctrl.sv
`timescale 1ns/1ps

module tb_pcxt_ctrl;

	logic        CLK_50M;
	logic        reset_wire;
	logic [63:0] status;
	logic        biu_done;
	logic        port_b_sel;
	logic        ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_data;
	logic        ioctl_download;
	logic [7:0]  ioctl_index;
	logic        tandy_mode, mda_mode, adlib_hide, ems_enabled;
	logic [1:0]  ems_frame, cpu_speed, floppy_wp, vga_sl;
	logic [2:0]  screen_mode;
	logic        scandoubler, hq2x, color_mode, turbo_mode;
	logic [12:0] video_arx, video_ary;
	logic [3:0]  dip_nibble;
	logic        ioctl_wait, rom_wr, rom_download;
	logic [24:0] rom_addr;
	logic [7:0]  rom_data, rom_index;
	logic        sys_reset, cpu_reset, sample_en;

	// Run bookkeeping
	int          errors, tests, fails, err_start;
	int          fd, code, cycle, sys_fall, cpu_fall, pulses, n, tail;
	string       line;
	byte         kind;
	logic [63:0] st;
	logic [12:0] e [0:14];
	logic [24:0] l_addr;
	logic [7:0]  l_idx;
	logic        l_dl;

	pcxt_ctrl_top i_dut (.*);

	always #10 CLK_50M = ~CLK_50M;

	// One ns past the edge, outputs are settled
	task automatic tick;
		@(posedge CLK_50M);
		#1;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == err_start) begin
			$display("test %0d %s ok", tests, name);
		end else begin
			fails++;
			$display("test %0d %s failed", tests, name);
		end
	endtask

	task automatic check_decode(input logic [47:0] got, input logic [47:0] exp);
		if (got !== exp) begin
			errors++;
			$display("error %0t: decode got %h expected %h", $time, got, exp);
		end
	endtask

	task automatic check_rom_byte(input pcxt_ctrl_pkg::rom_word_t w, input logic hi,
		input logic [24:0] addr, input logic [7:0] idx, input logic dl);
		logic [7:0] exp_byte;
		exp_byte = hi ? w.bytes.hi : w.bytes.lo;
		if (rom_wr !== 1'b1 || ioctl_wait !== 1'b1 || rom_data !== exp_byte ||
			rom_addr !== addr || rom_index !== idx || rom_download !== dl) begin
			errors++;
			$display("error %0t: byte wr %b wait %b data %h@%h expected %h@%h", $time,
				rom_wr, ioctl_wait, rom_data, rom_addr, exp_byte, addr);
		end
	endtask

	task automatic check_reset(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("error %0t: %s released after %0d clocks, expected %0d", $time,
				what, got, exp);
		end
	endtask

	task automatic check_count(input int got, input int exp, input string what);
		if (got != exp) begin
			errors++;
			$display("error %0t: %s count %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// Counts byte writes seen over a window
	task automatic count_writes(input int cycles, output int cnt);
		cnt = 0;
		for (int i = 0; i < cycles; i++) begin
			tick;
			if (rom_wr) begin
				cnt++;
			end
		end
	endtask

	task automatic load_word(input logic [24:0] addr, input logic [7:0] idx, input logic dl);
		pcxt_ctrl_pkg::rom_word_t w;
		int wait_cnt;
		w.word = 16'($urandom());
		ioctl_wr       = 1'b1;
		ioctl_addr     = addr;
		ioctl_data     = w.word;
		ioctl_index    = idx;
		ioctl_download = dl;
		tick;
		#1;
		ioctl_wr = 1'b0;
		wait_cnt = 0;
		while (!rom_wr && wait_cnt < 20) begin
			tick;
			#1;
			wait_cnt++;
		end
		if (!rom_wr) begin
			errors++;
			$display("timeout: no ROM write after host word at %h", addr);
		end else begin
			// Low byte first, then high byte one clock later
			check_rom_byte(w, 1'b0, addr, idx, dl);
			tick;
			check_rom_byte(w, 1'b1, addr + 25'd1, idx, dl);
			tick;
			check_count(int'(rom_wr) + int'(ioctl_wait), 0, "strobes after word");
		end
		tick;
		#1;
	endtask

	initial begin
		errors = 0;
		tests = 0;
		fails = 0;
		void'($urandom(32'h1400));
		CLK_50M = 1'b0;
		reset_wire = 1'b1;
		status = 64'd0;
		biu_done = 1'b0;
		port_b_sel = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_data = 16'd0;
		ioctl_download = 1'b0;
		ioctl_index = 8'd0;
		repeat (10) tick;
		// Loader and audio idle, both resets held
		err_start = errors;
		if (rom_wr || ioctl_wait || sample_en || !sys_reset || !cpu_reset) begin
			errors++;
			$display("error %0t: outputs not in their reset state", $time);
		end
		#1;
		reset_wire = 1'b0;

		////////////////////////////////////////
		// Reset release and sample rate
		////////////////////////////////////////
		cycle = 0;
		sys_fall = 0;
		cpu_fall = 0;
		pulses = 0;
		while (cpu_fall == 0 && cycle < 70000) begin
			tick;
			cycle++;
			if (cycle <= 50000 && sample_en) begin
				pulses++;
			end
			if (sys_fall == 0 && !sys_reset) begin
				sys_fall = cycle;
			end
			if (!cpu_reset) begin
				cpu_fall = cycle;
			end else if (rom_wr || ioctl_wait) begin
				errors++;
				$display("error %0t: loader active during reset", $time);
			end
		end
		if (cpu_fall == 0) begin
			errors++;
			$display("timeout: CPU reset never released");
		end
		check_reset(sys_fall, 65536, "system reset");
		check_reset(cpu_fall - sys_fall, 44, "CPU reset");
		finish_test("reset release");
		err_start = errors;
		check_count(pulses, 44, "sample enable");
		finish_test("sample rate");

		////////////////////////////////////////
		// File driven vectors
		////////////////////////////////////////
		fd = $fopen("tb/pcxt_ctrl_tests.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open the test vector file");
		end else begin
			#1;
			while (!$feof(fd)) begin
				code = $fgets(line, fd);
				// Nothing read at end of file
				if (code == 0) begin
					line = "";
				end
				code = $sscanf(line, "%c", kind);
				if (code == 1 && kind == "D") begin
					err_start = errors;
					code = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						kind, st, n, e[0], e[1], e[2], e[3], e[4], e[5], e[6], e[7],
						e[8], e[9], e[10], e[11], e[12], e[13], e[14]);
					status = st;
					port_b_sel = n[0];
					tick;
					tick;
					check_decode({tandy_mode, mda_mode, adlib_hide, ems_enabled, ems_frame,
						cpu_speed, floppy_wp, screen_mode, vga_sl, scandoubler, hq2x,
						color_mode, video_arx, video_ary, dip_nibble},
						{e[0][0], e[1][0], e[2][0], e[3][0], e[4][1:0], e[5][1:0],
						e[6][1:0], e[7][2:0], e[8][1:0], e[9][0], e[10][0], e[11][0],
						e[12], e[13], e[14][3:0]});
					#1;
					finish_test("status decode");
				end else if (code == 1 && kind == "T") begin
					// Speed field, BIU strobe, turbo afterwards
					err_start = errors;
					code = $sscanf(line, "%c %h %h %h", kind, e[0], e[1], e[2]);
					status = {45'd0, e[0][1:0], 17'd0};
					biu_done = e[1][0];
					tick;
					#1;
					biu_done = 1'b0;
					tick;
					check_count(int'(turbo_mode), int'(e[2][0]), "turbo flag");
					#1;
					finish_test("turbo latch");
				end else if (code == 1 && kind == "L") begin
					err_start = errors;
					code = $sscanf(line, "%c %h %h %h", kind, l_addr, l_idx, l_dl);
					load_word(l_addr, l_idx, l_dl);
					finish_test("download split");
				end
			end
			$fclose(fd);
		end

		////////////////////////////////////////
		// Strobe held across a word
		////////////////////////////////////////
		err_start = errors;
		ioctl_wr = 1'b1;
		ioctl_data = 16'($urandom());
		count_writes(8, n);
		check_count(n, 2, "writes with strobe held");
		#1;
		ioctl_wr = 1'b0;
		count_writes(4, n);
		check_count(n, 0, "writes after strobe drop");
		#1;
		ioctl_wr = 1'b1;
		count_writes(1, n);
		#1;
		ioctl_wr = 1'b0;
		count_writes(6, tail);
		check_count(n + tail, 2, "writes of next word");
		finish_test("back to back");

		$display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule
